/* test/board_i2c_cases.txt */
// one word per case: tag, field a, field b, field c (hex bytes)
// 01 eeprom reg/value, 02 init reg/data, 03 host write reg/-/nack, 04 host read reg/-/nack
// 05 absent dev/reg/nack, 06 pll reset reg/first/second, 07 init restart
018cc000
019ca800
01ac0100
01bc2a00
01cc4e00
01dc1700
016c5d00
02170400
02184000
021ee800
021f8000
022d0100
022e1000
02603b00
03450000
04ac0000
048c0000
05331201
06764363
07000000
03460000
046c0000

/* flist.f */
+incdir+src
src/i2c_cmd_pkg.sv
src/i2c_bus_pkg.sv
src/i2c_bit_engine.sv
src/i2c_bus_master.sv
src/board_init_seq.sv
src/board_i2c_top.sv
test/i2c_target_model.sv
test/board_i2c_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= board_i2c_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= test passed
SOURCES   := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/board_i2c_tb.sv */
`timescale 1ns/1ns
`include "i2c_config.svh"

module board_i2c_tb
  import i2c_cmd_pkg::*;
();

  localparam int MAX_CASES  = 64;
  localparam int WAIT_LIMIT = 20000;  // cycles per wait

  logic        clk;
  logic        versa_rst;
  logic        init_start_i;
  logic [5:0]  cmd_addr_i;
  logic [31:0] cmd_data_i;
  logic        cmd_rqst_i;
  logic        cmd_ack_o;
  logic [31:0] cmd_resp_data_o;
  logic        init_done_o;
  logic [31:0] static_ip_o;
  logic [15:0] alt_mac_o;
  logic [7:0]  eeprom_config_o;
  logic        scl1_o;
  logic        scl1_t_o;
  logic        sda1_o;
  logic        sda1_t_o;
  logic        scl2_o;
  logic        scl2_t_o;
  logic        sda2_o;
  logic        sda2_t_o;
  logic        clk_sda_pull;
  logic        ee_sda_pull;
  wire         scl1;
  wire         sda1;
  wire         scl2;
  wire         sda2;

  logic [31:0] cases [0:MAX_CASES-1];
  logic [7:0]  ee_img [0:255];
  logic [7:0]  init_reg [0:15];
  logic [7:0]  init_dat [0:15];
  int          n_init;
  int          n_cases;
  int          errors;
  int          tests;
  int          failed_tests;

  // wired-AND with pullup
  assign scl1 = scl1_t_o | scl1_o;
  assign sda1 = (sda1_t_o | sda1_o) & ~clk_sda_pull;
  assign scl2 = scl2_t_o | scl2_o;
  assign sda2 = (sda2_t_o | sda2_o) & ~ee_sda_pull;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  board_i2c_top DUT (
    .clk             (clk),
    .versa_rst       (versa_rst),
    .init_start_i    (init_start_i),
    .cmd_addr_i      (cmd_addr_i),
    .cmd_data_i      (cmd_data_i),
    .cmd_rqst_i      (cmd_rqst_i),
    .cmd_ack_o       (cmd_ack_o),
    .cmd_resp_data_o (cmd_resp_data_o),
    .init_done_o     (init_done_o),
    .static_ip_o     (static_ip_o),
    .alt_mac_o       (alt_mac_o),
    .eeprom_config_o (eeprom_config_o),
    .scl1_i          (scl1),
    .scl1_o          (scl1_o),
    .scl1_t_o        (scl1_t_o),
    .sda1_i          (sda1),
    .sda1_o          (sda1_o),
    .sda1_t_o        (sda1_t_o),
    .scl2_i          (scl2),
    .scl2_o          (scl2_o),
    .scl2_t_o        (scl2_t_o),
    .sda2_i          (sda2),
    .sda2_o          (sda2_o),
    .sda2_t_o        (sda2_t_o)
  );

  i2c_target_model #(.DEV_ADDR(7'h6a)) clkgen_model (
    .scl_i      (scl1),
    .sda_i      (sda1),
    .sda_pull_o (clk_sda_pull)
  );

  i2c_target_model #(.DEV_ADDR(7'h56)) eeprom_model (
    .scl_i      (scl2),
    .sda_i      (sda2),
    .sda_pull_o (ee_sda_pull)
  );

  function automatic logic [7:0] fill_byte(input int addr);
    return 8'(addr * 37 + 91);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("** Error %s: expected %h, actual %h", name, exp, act);
    errors++;
  endtask

  task automatic report_failure(input string name, input string what);
    $display("%s: %s", name, what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("ok   %s", name);
    end else begin
      failed_tests++;
      $display("FAIL %s", name);
    end
  endtask

  task automatic send_rqst(input logic [5:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    cmd_addr_i = addr;
    cmd_data_i = data;
    cmd_rqst_i = 1'b1;
    @(posedge clk);
    #1;
    cmd_rqst_i = 1'b0;
  endtask

  task automatic host_cmd(input logic [5:0] addr, input logic [31:0] data,
                          output bit acked, output logic [31:0] resp);
    int n;
    n     = 0;
    acked = 0;
    resp  = '0;
    send_rqst(addr, data);
    while (!acked && n < WAIT_LIMIT) begin
      @(negedge clk);
      if (cmd_ack_o) begin
        acked = 1;
        resp  = cmd_resp_data_o;
      end
      n++;
    end
  endtask

  task automatic wait_init_done(output bit ok);
    int n;
    n  = 0;
    ok = 0;
    while (!ok && n < WAIT_LIMIT) begin
      @(negedge clk);
      ok = init_done_o;
      n++;
    end
  endtask

  // two reset writes, then their stops
  task automatic wait_pll_writes(input int log_target, input int stop_target,
                                 output bit ok, output bit acked);
    int n;
    n     = 0;
    acked = 0;
    ok    = 0;
    while (!ok && n < WAIT_LIMIT) begin
      @(negedge clk);
      if (cmd_ack_o) acked = 1;
      ok = (clkgen_model.log_count >= log_target) &&
           (clkgen_model.stop_count >= stop_target);
      n++;
    end
  endtask

  task automatic check_init_log(input string name, input int first);
    if (clkgen_model.log_count != first + n_init)
      report_mismatch({name, " write count"}, first + n_init, clkgen_model.log_count);
    for (int i = 0; i < n_init; i++) begin
      if ({clkgen_model.log_reg[first+i], clkgen_model.log_dat[first+i]} !==
          {init_reg[i], init_dat[i]})
        report_mismatch($sformatf("%s write %0d", name, i), {init_reg[i], init_dat[i]},
                        {clkgen_model.log_reg[first+i], clkgen_model.log_dat[first+i]});
    end
  endtask

  initial begin
    bit          ok;
    bit          acked;
    logic [31:0] resp;
    logic [7:0]  tag;
    logic [7:0]  fa;
    logic [7:0]  fb;
    logic [7:0]  fc;
    logic [7:0]  wdat;
    int          err0;
    int          log0;
    int          elog0;
    int          stop0;
    string       name;

    versa_rst    = 1'b1;
    init_start_i = 1'b1;
    cmd_addr_i   = '0;
    cmd_data_i   = '0;
    cmd_rqst_i   = 1'b0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    n_init       = 0;
    n_cases      = 0;
    void'($urandom(32'hcc7c_208b));

    for (int i = 0; i < MAX_CASES; i++) cases[i] = '0;
    $readmemh("test/board_i2c_cases.txt", cases);
    for (int i = 0; i < 256; i++) begin
      ee_img[i]            = fill_byte(i);
      eeprom_model.mem[i]  = ee_img[i];
      clkgen_model.mem[i]  = fill_byte(255 - i);
    end
    for (int i = 0; i < MAX_CASES; i++) begin
      tag = cases[i][31:24];
      fa  = cases[i][23:16];
      fb  = cases[i][15:8];
      if (tag != 8'h00) n_cases++;
      if (tag == 8'h01) begin
        ee_img[fa]           = fb;
        eeprom_model.mem[fa] = fb;
      end else if (tag == 8'h02 && n_init < 16) begin
        init_reg[n_init] = fa;
        init_dat[n_init] = fb;
        n_init++;
      end
    end

    fork
      begin
        #(n_cases * 60 * 4 * `I2C_QUARTER_CYCLES * 8 * 2);
        $display("watchdog: the run took longer than its time budget");
        $display("test failed");
        $finish;
      end
    join_none

    repeat (3) @(posedge clk);
    #1;
    versa_rst = 1'b0;

    // ########################################################################
    // init sequence after reset

    err0 = errors;
    wait_init_done(ok);
    if (!ok) report_failure("init_table", "init_done_o never rose");
    check_init_log("init_table", 0);
    if (eeprom_model.log_count != 0)
      report_mismatch("init_table eeprom writes", 0, eeprom_model.log_count);
    finish_test("init_table", err0);

    err0 = errors;
    if (static_ip_o !== {ee_img[8'h8c], ee_img[8'h9c], ee_img[8'hac], ee_img[8'hbc]})
      report_mismatch("eeprom_capture ip",
                      {ee_img[8'h8c], ee_img[8'h9c], ee_img[8'hac], ee_img[8'hbc]},
                      static_ip_o);
    if (alt_mac_o !== {ee_img[8'hcc], ee_img[8'hdc]})
      report_mismatch("eeprom_capture mac", {ee_img[8'hcc], ee_img[8'hdc]}, alt_mac_o);
    if (eeprom_config_o !== ee_img[8'h6c])
      report_mismatch("eeprom_capture config", ee_img[8'h6c], eeprom_config_o);
    finish_test("eeprom_capture", err0);

    // ########################################################################
    // host cases in file order

    for (int i = 0; i < MAX_CASES; i++) begin
      tag   = cases[i][31:24];
      fa    = cases[i][23:16];
      fb    = cases[i][15:8];
      fc    = cases[i][7:0];
      err0  = errors;
      log0  = clkgen_model.log_count;
      elog0 = eeprom_model.log_count;
      stop0 = clkgen_model.stop_count;
      wdat  = 8'($urandom);
      case (tag)
        8'h03: begin
          name = $sformatf("host_write_%0d", i);
          host_cmd(`CMD_ADDR_WRITE, {OP_WRITE, 1'b1, `CLKGEN_DEV, fa, wdat}, acked, resp);
          if (!acked) report_failure(name, "no ack for the host write");
          else if (resp[0] !== fc[0]) report_mismatch({name, " nack"}, fc[0], resp[0]);
          if (clkgen_model.log_count != log0 + 1)
            report_mismatch({name, " count"}, log0 + 1, clkgen_model.log_count);
          else if ({clkgen_model.log_reg[log0], clkgen_model.log_dat[log0]} !== {fa, wdat})
            report_mismatch({name, " write"}, {fa, wdat},
                            {clkgen_model.log_reg[log0], clkgen_model.log_dat[log0]});
          finish_test(name, err0);
        end
        8'h04: begin
          name = $sformatf("host_read_%0d", i);
          host_cmd(`CMD_ADDR_READ, {OP_READ, `EEPROM_DEV, fa, 8'h00}, acked, resp);
          if (!acked) report_failure(name, "no ack for the host read");
          else begin
            if (resp[15:8] !== ee_img[fa]) report_mismatch(name, ee_img[fa], resp[15:8]);
            if (resp[0] !== fc[0]) report_mismatch({name, " nack"}, fc[0], resp[0]);
          end
          finish_test(name, err0);
        end
        8'h05: begin
          name = $sformatf("absent_device_%0d", i);
          host_cmd(`CMD_ADDR_WRITE, {OP_WRITE, 1'b1, fa[6:0], fb, wdat}, acked, resp);
          if (!acked) report_failure(name, "no ack for the write to an absent device");
          else if (resp[0] !== fc[0]) report_mismatch({name, " nack"}, fc[0], resp[0]);
          if (clkgen_model.log_count != log0)
            report_mismatch({name, " clkgen log"}, log0, clkgen_model.log_count);
          if (eeprom_model.log_count != elog0)
            report_mismatch({name, " eeprom log"}, elog0, eeprom_model.log_count);
          finish_test(name, err0);
        end
        8'h06: begin
          name = $sformatf("pll_reset_%0d", i);
          send_rqst(`CMD_ADDR_PLL_RESET, 32'h0000_0001);
          wait_pll_writes(log0 + 2, stop0 + 2, ok, acked);
          // rest of the last stop bit, where its ack would land
          for (int k = 0; k < 4 * `I2C_QUARTER_CYCLES; k++) begin
            @(negedge clk);
            if (cmd_ack_o) acked = 1;
          end
          if (!ok) report_failure(name, "the two reset writes never completed");
          if (acked) report_failure(name, "the host saw an ack for the reset request");
          if ({clkgen_model.log_reg[log0], clkgen_model.log_dat[log0]} !== {fa, fb})
            report_mismatch({name, " first"}, {fa, fb},
                            {clkgen_model.log_reg[log0], clkgen_model.log_dat[log0]});
          if ({clkgen_model.log_reg[log0+1], clkgen_model.log_dat[log0+1]} !== {fa, fc})
            report_mismatch({name, " second"}, {fa, fc},
                            {clkgen_model.log_reg[log0+1], clkgen_model.log_dat[log0+1]});
          finish_test(name, err0);
        end
        8'h07: begin
          name = $sformatf("init_restart_%0d", i);
          @(posedge clk);
          #1;
          init_start_i = 1'b0;
          @(posedge clk);  // sequencer sees the drop here
          @(negedge clk);
          if (init_done_o !== 1'b0) report_mismatch({name, " done low"}, 0, init_done_o);
          @(posedge clk);
          #1;
          init_start_i = 1'b1;
          wait_init_done(ok);
          if (!ok) report_failure(name, "init_done_o never rose again");
          check_init_log(name, log0);
          if (eeprom_model.log_count != elog0)
            report_mismatch({name, " eeprom log"}, elog0, eeprom_model.log_count);
          finish_test(name, err0);
        end
        default: ;
      endcase
    end

    $display("summary: %0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* test/i2c_target_model.sv */
`timescale 1ns/1ns

module i2c_target_model #(
  parameter logic [6:0] DEV_ADDR = 7'h6a
) (
  input  logic scl_i,
  input  logic sda_i,
  output logic sda_pull_o
);

  logic [7:0] mem [0:255];
  logic [7:0] log_reg [0:63];
  logic [7:0] log_dat [0:63];
  int         log_count = 0;
  int         stop_count = 0;
  int         bit_cnt = 0;
  int         byte_idx = 0;
  logic       active = 1'b0;
  logic       in_ack = 1'b0;
  logic       sending = 1'b0;  // target drives read data
  logic [7:0] shift_q = 8'h00;
  logic [7:0] ptr = 8'h00;
  logic [7:0] tx_byte = 8'h00;

  initial sda_pull_o = 1'b0;

  // start or repeated start
  always @(negedge sda_i) begin
    if (scl_i) begin
      active   = 1'b1;
      in_ack   = 1'b0;
      sending  = 1'b0;
      bit_cnt  = 0;
      byte_idx = 0;
    end
  end

  always @(posedge sda_i) begin
    if (scl_i) begin
      active = 1'b0;
      stop_count++;
    end
  end

  always @(posedge scl_i) begin
    if (active && !in_ack && !sending) shift_q = {shift_q[6:0], sda_i};
    if (active && !in_ack) bit_cnt++;
  end

  // ##########################################################################
  // sda changes only while scl is low

  always @(negedge scl_i) begin
    if (!active) begin
      sda_pull_o = 1'b0;
    end else if (in_ack) begin
      in_ack  = 1'b0;
      bit_cnt = 0;
      if (sending) begin
        tx_byte    = mem[ptr];
        ptr        = ptr + 8'd1;
        sda_pull_o = !tx_byte[7];
      end else begin
        sda_pull_o = 1'b0;
      end
    end else if (bit_cnt == 8) begin
      if (sending) begin
        sda_pull_o = 1'b0;  // single byte reads, master nacks
        active     = 1'b0;
      end else begin
        in_ack     = 1'b1;
        sda_pull_o = 1'b1;
        if (byte_idx == 0) begin
          if (shift_q[7:1] == DEV_ADDR) begin
            sending = shift_q[0];
          end else begin
            sda_pull_o = 1'b0;  // not our address
            active     = 1'b0;
          end
        end else if (byte_idx == 1) begin
          ptr = shift_q;
        end else begin
          mem[ptr] = shift_q;
          if (log_count < 64) begin
            log_reg[log_count] = ptr;
            log_dat[log_count] = shift_q;
            log_count++;
          end
          ptr = ptr + 8'd1;
        end
        byte_idx++;
      end
    end else if (sending) begin
      sda_pull_o = !tx_byte[7 - bit_cnt];
    end
  end

endmodule

/* src/board_i2c_top.sv */
`timescale 1ns/1ns

module board_i2c_top
  import i2c_bus_pkg::*;
(
  input  logic        clk,
  input  logic        versa_rst,
  input  logic        init_start_i,
  input  logic [5:0]  cmd_addr_i,
  input  logic [31:0] cmd_data_i,
  input  logic        cmd_rqst_i,
  output logic        cmd_ack_o,
  output logic [31:0] cmd_resp_data_o,
  output logic        init_done_o,
  output logic [31:0] static_ip_o,
  output logic [15:0] alt_mac_o,
  output logic [7:0]  eeprom_config_o,
  input  logic        scl1_i,
  output logic        scl1_o,
  output logic        scl1_t_o,
  input  logic        sda1_i,
  output logic        sda1_o,
  output logic        sda1_t_o,
  input  logic        scl2_i,
  output logic        scl2_o,
  output logic        scl2_t_o,
  input  logic        sda2_i,
  output logic        sda2_o,
  output logic        sda2_t_o
);

  logic [31:0] mst_cmd_data;
  logic        mst_cmd_rqst;
  logic        mst_cmd_ack;
  logic [31:0] mst_resp_data;
  logic        mst_ready;
  bus_sel_e    mst_bus_sel;
  logic        scl_i;
  logic        scl_o;
  logic        scl_t;
  logic        sda_i;
  logic        sda_o;
  logic        sda_t;

  board_init_seq u_init_seq (
    .clk             (clk),
    .versa_rst       (versa_rst),
    .init_start_i    (init_start_i),
    .cmd_addr_i      (cmd_addr_i),
    .cmd_data_i      (cmd_data_i),
    .cmd_rqst_i      (cmd_rqst_i),
    .mst_ready_i     (mst_ready),
    .mst_cmd_ack_i   (mst_cmd_ack),
    .mst_resp_data_i (mst_resp_data),
    .mst_bus_sel_i   (mst_bus_sel),
    .mst_scl_o_i     (scl_o),
    .mst_scl_t_i     (scl_t),
    .mst_sda_o_i     (sda_o),
    .mst_sda_t_i     (sda_t),
    .scl1_i          (scl1_i),
    .sda1_i          (sda1_i),
    .scl2_i          (scl2_i),
    .sda2_i          (sda2_i),
    .mst_cmd_data_o  (mst_cmd_data),
    .mst_cmd_rqst_o  (mst_cmd_rqst),
    .cmd_ack_o       (cmd_ack_o),
    .cmd_resp_data_o (cmd_resp_data_o),
    .init_done_o     (init_done_o),
    .static_ip_o     (static_ip_o),
    .alt_mac_o       (alt_mac_o),
    .eeprom_config_o (eeprom_config_o),
    .mst_scl_i_o     (scl_i),
    .mst_sda_i_o     (sda_i),
    .scl1_o          (scl1_o),
    .scl1_t_o        (scl1_t_o),
    .sda1_o          (sda1_o),
    .sda1_t_o        (sda1_t_o),
    .scl2_o          (scl2_o),
    .scl2_t_o        (scl2_t_o),
    .sda2_o          (sda2_o),
    .sda2_t_o        (sda2_t_o)
  );

  i2c_bus_master u_bus_master (
    .clk             (clk),
    .versa_rst       (versa_rst),
    .cmd_data_i      (mst_cmd_data),
    .cmd_rqst_i      (mst_cmd_rqst),
    .scl_i           (scl_i),
    .sda_i           (sda_i),
    .cmd_ack_o       (mst_cmd_ack),
    .cmd_resp_data_o (mst_resp_data),
    .ready_o         (mst_ready),
    .bus_sel_o       (mst_bus_sel),
    .scl_o           (scl_o),
    .scl_t_o         (scl_t),
    .sda_o           (sda_o),
    .sda_t_o         (sda_t)
  );

endmodule

/* src/board_init_seq.sv */
`timescale 1ns/1ns
`include "i2c_config.svh"

module board_init_seq
  import i2c_cmd_pkg::*;
  import i2c_bus_pkg::*;
(
  input  logic        clk,
  input  logic        versa_rst,
  input  logic        init_start_i,
  input  logic [5:0]  cmd_addr_i,
  input  logic [31:0] cmd_data_i,
  input  logic        cmd_rqst_i,
  input  logic        mst_ready_i,
  input  logic        mst_cmd_ack_i,
  input  logic [31:0] mst_resp_data_i,
  input  bus_sel_e    mst_bus_sel_i,
  input  logic        mst_scl_o_i,
  input  logic        mst_scl_t_i,
  input  logic        mst_sda_o_i,
  input  logic        mst_sda_t_i,
  input  logic        scl1_i,
  input  logic        sda1_i,
  input  logic        scl2_i,
  input  logic        sda2_i,
  output logic [31:0] mst_cmd_data_o,
  output logic        mst_cmd_rqst_o,
  output logic        cmd_ack_o,
  output logic [31:0] cmd_resp_data_o,
  output logic        init_done_o,
  output logic [31:0] static_ip_o,
  output logic [15:0] alt_mac_o,
  output logic [7:0]  eeprom_config_o,
  output logic        mst_scl_i_o,
  output logic        mst_sda_i_o,
  output logic        scl1_o,
  output logic        scl1_t_o,
  output logic        sda1_o,
  output logic        sda1_t_o,
  output logic        scl2_o,
  output logic        scl2_t_o,
  output logic        sda2_o,
  output logic        sda2_t_o
);

  typedef enum logic [1:0] {
    ST_INIT_WR, ST_EE_RD, ST_PASS, ST_PLL_RST
  } seq_state_e;

  localparam logic [0:6][7:0] INIT_REG = '{8'h17, 8'h18, 8'h1e, 8'h1f, 8'h2d, 8'h2e, 8'h60};
  localparam logic [0:6][7:0] INIT_DAT = '{8'h04, 8'h40, 8'he8, 8'h80, 8'h01, 8'h10, 8'h3b};
  localparam logic [0:6][7:0] EE_REG   = '{8'h8c, 8'h9c, 8'hac, 8'hbc, 8'hcc, 8'hdc, 8'h6c};

  seq_state_e state_q;
  logic [2:0] step_q;
  logic       busy_q;
  logic       step_ack;
  logic       step_last;
  logic       seq_rqst;
  logic       host_fwd;
  logic       pll_reset_req;
  logic [7:0] rd_byte;
  logic       on_eeprom;

  assign rd_byte       = mst_resp_data_i[15:8];
  assign step_ack      = mst_cmd_ack_i && busy_q;  // stale acks after a restart drop out
  assign step_last     = (state_q == ST_PLL_RST) ? (step_q == 3'd1) : (step_q == 3'd6);
  assign seq_rqst      = init_start_i && mst_ready_i && !busy_q;
  assign pll_reset_req = cmd_rqst_i && (cmd_addr_i == `CMD_ADDR_PLL_RESET) && cmd_data_i[0];
  assign host_fwd      = cmd_rqst_i && mst_ready_i && !busy_q &&
                         ((cmd_addr_i == `CMD_ADDR_WRITE) || (cmd_addr_i == `CMD_ADDR_READ));

  assign init_done_o     = (state_q == ST_PASS) || (state_q == ST_PLL_RST);
  assign cmd_ack_o       = step_ack && (state_q == ST_PASS);  // host sees only its own
  assign cmd_resp_data_o = mst_resp_data_i;

  always_comb begin
    mst_cmd_rqst_o = seq_rqst;
    case (state_q)
      ST_INIT_WR: mst_cmd_data_o = {OP_WRITE, 1'b1, `CLKGEN_DEV, INIT_REG[step_q],
                                    INIT_DAT[step_q]};
      ST_EE_RD:   mst_cmd_data_o = {OP_READ, `EEPROM_DEV, EE_REG[step_q], 8'h00};
      ST_PLL_RST: mst_cmd_data_o = {OP_WRITE, 1'b1, `CLKGEN_DEV, 8'h76,
                                    step_q[0] ? 8'h63 : 8'h43};
      default: begin
        mst_cmd_data_o = cmd_data_i;
        mst_cmd_rqst_o = host_fwd;
      end
    endcase
  end

  // ##########################################################################
  // init walker and pass-through

  always_ff @(posedge clk) begin
    if (versa_rst) begin
      state_q         <= ST_INIT_WR;
      step_q          <= '0;
      busy_q          <= 1'b0;
      static_ip_o     <= '0;
      alt_mac_o       <= '0;
      eeprom_config_o <= '0;
    end else if (!init_start_i) begin
      state_q <= ST_INIT_WR;
      step_q  <= '0;
      busy_q  <= 1'b0;
    end else begin
      if (mst_cmd_rqst_o) begin
        busy_q <= 1'b1;
      end else if (step_ack) begin
        busy_q <= 1'b0;
      end
      if (step_ack && state_q != ST_PASS) begin
        step_q <= step_last ? 3'd0 : step_q + 3'd1;
        if (step_last) state_q <= (state_q == ST_INIT_WR) ? ST_EE_RD : ST_PASS;
      end
      if (state_q == ST_PASS && pll_reset_req && mst_ready_i && !busy_q) begin
        state_q <= ST_PLL_RST;
      end
      if (step_ack && state_q == ST_EE_RD) begin
        case (step_q)
          3'd0:    static_ip_o[31:24] <= rd_byte;  // msb first
          3'd1:    static_ip_o[23:16] <= rd_byte;
          3'd2:    static_ip_o[15:8]  <= rd_byte;
          3'd3:    static_ip_o[7:0]   <= rd_byte;
          3'd4:    alt_mac_o[15:8]    <= rd_byte;
          3'd5:    alt_mac_o[7:0]     <= rd_byte;
          default: eeprom_config_o    <= rd_byte;
        endcase
      end
    end
  end

  // ##########################################################################
  // bus steering

  assign on_eeprom   = (mst_bus_sel_i == BUS_EEPROM);
  assign mst_scl_i_o = on_eeprom ? scl2_i : scl1_i;
  assign mst_sda_i_o = on_eeprom ? sda2_i : sda1_i;

  assign scl1_o   = mst_scl_o_i;
  assign sda1_o   = mst_sda_o_i;
  assign scl2_o   = mst_scl_o_i;
  assign sda2_o   = mst_sda_o_i;
  assign scl1_t_o = on_eeprom ? 1'b1 : mst_scl_t_i;  // idle bus stays released
  assign sda1_t_o = on_eeprom ? 1'b1 : mst_sda_t_i;
  assign scl2_t_o = on_eeprom ? mst_scl_t_i : 1'b1;
  assign sda2_t_o = on_eeprom ? mst_sda_t_i : 1'b1;

endmodule

/* src/i2c_bus_master.sv */
`timescale 1ns/1ns

module i2c_bus_master
  import i2c_cmd_pkg::*;
  import i2c_bus_pkg::*;
(
  input  logic        clk,
  input  logic        versa_rst,
  input  logic [31:0] cmd_data_i,
  input  logic        cmd_rqst_i,
  input  logic        scl_i,
  input  logic        sda_i,
  output logic        cmd_ack_o,
  output logic [31:0] cmd_resp_data_o,
  output logic        ready_o,
  output bus_sel_e    bus_sel_o,
  output logic        scl_o,
  output logic        scl_t_o,
  output logic        sda_o,
  output logic        sda_t_o
);

  typedef enum logic [2:0] {
    M_IDLE, M_START, M_TX, M_ACK, M_RESTART, M_RX, M_NACK, M_STOP
  } mst_state_e;

  mst_state_e state_q;
  cmd_word_u  cmd_in;
  cmd_word_u  cmd_q;
  logic       is_read;
  logic [1:0] byte_q;
  logic [2:0] bit_cnt_q;
  logic [7:0] tx_byte;
  logic [7:0] rx_q;
  logic       nack_q;
  logic       wait_q;
  logic       ack_q;
  bit_op_e    bit_op;
  logic       bit_start;
  logic       bit_wdata;
  logic       bit_done;
  logic       bit_rdata;

  assign cmd_in          = cmd_data_i;
  assign is_read         = (cmd_q.rd.op == OP_READ);
  assign ready_o         = (state_q == M_IDLE);
  assign cmd_ack_o       = ack_q;
  assign cmd_resp_data_o = {16'h0000, rx_q, 7'h00, nack_q};
  assign bit_start       = !ready_o && !wait_q;  // one bit op per state visit

  // byte on the wire for each slot
  always_comb begin
    if (!is_read) begin
      case (byte_q)
        2'd0:    tx_byte = {cmd_q.wr.dev, 1'b0};
        2'd1:    tx_byte = cmd_q.wr.reg_addr;
        default: tx_byte = cmd_q.wr.data;
      endcase
    end else begin
      case (byte_q)
        2'd0:    tx_byte = {cmd_q.rd.dev[7:1], 1'b0};
        2'd1:    tx_byte = cmd_q.rd.reg_addr;
        default: tx_byte = {cmd_q.rd.dev[7:1], 1'b1};  // after restart
      endcase
    end
  end

  always_comb begin
    bit_wdata = 1'b1;  // released for ack slot and master nack
    case (state_q)
      M_START:   bit_op = BIT_START;
      M_RESTART: bit_op = BIT_RESTART;
      M_STOP:    bit_op = BIT_STOP;
      M_RX:      bit_op = BIT_READ;
      default:   bit_op = BIT_WRITE;
    endcase
    if (state_q == M_TX) bit_wdata = tx_byte[bit_cnt_q];
  end

  // ##########################################################################
  // transaction FSM

  always_ff @(posedge clk) begin
    if (versa_rst) begin
      state_q   <= M_IDLE;
      wait_q    <= 1'b0;
      ack_q     <= 1'b0;
      nack_q    <= 1'b0;
      rx_q      <= '0;
      byte_q    <= '0;
      bit_cnt_q <= 3'd7;
      bus_sel_o <= BUS_CLKGEN;
    end else begin
      ack_q <= 1'b0;
      if (bit_start) wait_q <= 1'b1;
      if (bit_done) wait_q <= 1'b0;
      case (state_q)
        M_IDLE: if (cmd_rqst_i) begin
          state_q   <= M_START;
          byte_q    <= '0;
          bit_cnt_q <= 3'd7;
          nack_q    <= 1'b0;
          rx_q      <= '0;
          bus_sel_o <= (cmd_in.rd.op == OP_READ) ? BUS_EEPROM : BUS_CLKGEN;
        end
        M_START, M_RESTART: if (bit_done) state_q <= M_TX;
        M_TX: if (bit_done) begin
          bit_cnt_q <= bit_cnt_q - 3'd1;  // wraps to 7 for the next byte
          if (bit_cnt_q == 3'd0) state_q <= M_ACK;
        end
        M_ACK: if (bit_done) begin
          byte_q <= byte_q + 2'd1;
          if (bit_rdata) begin
            nack_q  <= is_read || cmd_q.wr.ack_req;
            state_q <= M_STOP;
          end else if (byte_q == 2'd2) begin
            state_q <= is_read ? M_RX : M_STOP;
          end else if (is_read && byte_q == 2'd1) begin
            state_q <= M_RESTART;
          end else begin
            state_q <= M_TX;
          end
        end
        M_RX: if (bit_done) begin
          rx_q      <= {rx_q[6:0], bit_rdata};
          bit_cnt_q <= bit_cnt_q - 3'd1;
          if (bit_cnt_q == 3'd0) state_q <= M_NACK;
        end
        M_NACK: if (bit_done) state_q <= M_STOP;
        M_STOP: if (bit_done) begin
          state_q <= M_IDLE;
          ack_q   <= 1'b1;
        end
        default: state_q <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ready_o && cmd_rqst_i) cmd_q <= cmd_in;
  end

  i2c_bit_engine u_bit_engine (
    .clk         (clk),
    .versa_rst   (versa_rst),
    .bit_op_i    (bit_op),
    .bit_start_i (bit_start),
    .bit_wdata_i (bit_wdata),
    .scl_i       (scl_i),
    .sda_i       (sda_i),
    .bit_done_o  (bit_done),
    .bit_rdata_o (bit_rdata),
    .scl_o       (scl_o),
    .scl_t_o     (scl_t_o),
    .sda_o       (sda_o),
    .sda_t_o     (sda_t_o)
  );

endmodule

/* src/i2c_bit_engine.sv */
`timescale 1ns/1ns
`include "i2c_config.svh"

module i2c_bit_engine
  import i2c_bus_pkg::*;
(
  input  logic    clk,
  input  logic    versa_rst,
  input  bit_op_e bit_op_i,
  input  logic    bit_start_i,
  input  logic    bit_wdata_i,
  input  logic    scl_i,
  input  logic    sda_i,
  output logic    bit_done_o,
  output logic    bit_rdata_o,
  output logic    scl_o,
  output logic    scl_t_o,
  output logic    sda_o,
  output logic    sda_t_o
);

  localparam logic [7:0] QLAST = 8'(`I2C_QUARTER_CYCLES - 1);

  bit_op_e    op_q;
  logic       wdata_q;
  logic       busy_q;
  logic [7:0] qcnt_q;
  logic [1:0] phase_q;
  logic       scl_lvl_q;
  logic       sda_lvl_q;
  logic       rdata_q;
  logic       quarter_end;
  logic       scl_tgt;
  logic       sda_tgt;

  assign quarter_end = (qcnt_q == QLAST);
  assign bit_done_o  = busy_q && quarter_end && (phase_q == 2'd3);
  assign bit_rdata_o = rdata_q;

  // open drain so only a low is ever driven
  assign scl_o   = 1'b0;
  assign sda_o   = 1'b0;
  assign scl_t_o = scl_lvl_q;
  assign sda_t_o = sda_lvl_q;

  // line levels for each quarter of the bit
  always_comb begin
    case (op_q)
      BIT_START: begin
        scl_tgt = (phase_q < 2'd2);
        sda_tgt = (phase_q == 2'd0);  // sda falls with scl high
      end
      BIT_RESTART: begin
        scl_tgt = (phase_q == 2'd1) || (phase_q == 2'd2);
        sda_tgt = (phase_q < 2'd2);
      end
      BIT_STOP: begin
        scl_tgt = (phase_q != 2'd0);
        sda_tgt = (phase_q >= 2'd2);  // sda rises with scl high
      end
      default: begin
        scl_tgt = (phase_q == 2'd1) || (phase_q == 2'd2);
        sda_tgt = (op_q == BIT_READ) || wdata_q;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (versa_rst) begin
      busy_q    <= 1'b0;
      qcnt_q    <= '0;
      phase_q   <= '0;
      scl_lvl_q <= 1'b1;
      sda_lvl_q <= 1'b1;
      rdata_q   <= 1'b0;
    end else if (!busy_q) begin
      busy_q <= bit_start_i;
    end else begin
      scl_lvl_q <= scl_tgt;
      sda_lvl_q <= sda_tgt;
      qcnt_q    <= quarter_end ? '0 : qcnt_q + 8'd1;
      if (quarter_end) phase_q <= phase_q + 2'd1;
      if (bit_done_o) busy_q <= 1'b0;
      // scl midpoint, a stuck low clock reads as nack
      if (phase_q == 2'd2 && qcnt_q == '0) rdata_q <= scl_i ? sda_i : 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (bit_start_i && !busy_q) begin
      op_q    <= bit_op_i;
      wdata_q <= bit_wdata_i;
    end
  end

endmodule

/* src/i2c_bus_pkg.sv */
package i2c_bus_pkg;

  // one bit time on the wire
  typedef enum logic [2:0] {
    BIT_START,
    BIT_RESTART,
    BIT_STOP,
    BIT_WRITE,
    BIT_READ
  } bit_op_e;

  typedef enum logic {
    BUS_CLKGEN,  // bus 1
    BUS_EEPROM   // bus 2
  } bus_sel_e;

endpackage

/* src/i2c_cmd_pkg.sv */
package i2c_cmd_pkg;

  typedef enum logic [7:0] {
    OP_WRITE = 8'h06,
    OP_READ  = 8'h07
  } cmd_op_e;

  // register write with optional ack check
  typedef struct packed {
    cmd_op_e    op;
    logic       ack_req;
    logic [6:0] dev;
    logic [7:0] reg_addr;
    logic [7:0] data;
  } cmd_write_t;

  // single byte register read
  typedef struct packed {
    cmd_op_e    op;
    logic [7:0] dev;       // write form of the device byte
    logic [7:0] reg_addr;
    logic [7:0] unused;
  } cmd_read_t;

  // opcode sits in the top byte of both views
  typedef union packed {
    cmd_write_t wr;
    cmd_read_t  rd;
  } cmd_word_u;

endpackage

/* src/i2c_config.svh */
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// ##########################################################################
// bit timing

`define I2C_QUARTER_CYCLES 4

// ##########################################################################
// host command addresses

`define CMD_ADDR_WRITE     6'h3c
`define CMD_ADDR_READ      6'h3d
`define CMD_ADDR_PLL_RESET 6'h39

// ##########################################################################
// target devices

`define CLKGEN_DEV 7'h6a  // 7 bit address
`define EEPROM_DEV 8'hac  // write form of the address

`endif
